// ==== logic/bus_int_pkg.sv ====
// ----------------------------------------------------------------------
// Shared definitions for the board-control register block
// Bus widths, settings/readback address maps, field widths, identity
// ----------------------------------------------------------------------
package bus_int_pkg;

   // ------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------

   // Settings bus address
   localparam int SR_AWIDTH = 8;
   // Readback port address
   localparam int RB_AWIDTH = 8;
   // Settings data and readback data
   localparam int DATA_W    = 32;

   // ------------------------------------------------------------------
   // Address maps
   // ------------------------------------------------------------------

   // Settings bus registers, gaps left for blocks no longer present
   typedef enum logic [SR_AWIDTH-1:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9
   } sr_addr_e;

   // Readback words, anything else reads as zero
   typedef enum logic [RB_AWIDTH-1:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_ETH_TYPE0    = 8'd4,
      RB_ETH_TYPE1    = 8'd5,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9
   } rb_addr_e;

   // ------------------------------------------------------------------
   // Field widths
   // ------------------------------------------------------------------

   // Front panel LEDs
   localparam int LED_W        = 8;
   // Soft resets: PHY, radio domain, radio PLL, spare
   localparam int SW_RST_W     = 4;
   // Clock control outputs
   localparam int CLK_CTRL_W   = 7;
   // Clock status inputs
   localparam int CLK_STATUS_W = 5;
   // Rate select RS0/RS1 per cage
   localparam int SFPP_CTRL_W  = 2;
   // Ethernet PHY status per port
   localparam int PHY_STATUS_W = 16;
   // Cage pins: module absent, tx fault, rx loss of signal
   localparam int SFPP_PIN_W   = 3;

   // ------------------------------------------------------------------
   // Reset values and identity
   // ------------------------------------------------------------------

   // Bit 6 enables the GPS-disciplined oscillator out of reset
   localparam logic [CLK_CTRL_W-1:0] CLK_CTRL_AT_RESET = 7'b100_0000;

   // Compatibility number reported to host software
   localparam logic [15:0] COMPAT_MAJOR = 16'h000B;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   // Port build type, 1 means 10G
   localparam logic ETH10G_PORT0 = 1'b1;
   localparam logic ETH10G_PORT1 = 1'b0;

   // Depth of the pin synchronizers
   localparam int SYNC_STAGES = 2;

endpackage

// ==== logic/setting_reg.sv ====
// ----------------------------------------------------------------------
// Settings bus register, loads on a strobe at its own address
// ----------------------------------------------------------------------
module setting_reg
   import bus_int_pkg::*;
#(
   // Address this register answers to
   parameter sr_addr_e        MY_ADDR  = SR_LEDS,
   // Number of low data bits kept
   parameter int              WIDTH    = 8,
   // Value held out of reset
   parameter logic [WIDTH-1:0] AT_RESET = '0
) (
   input  logic                 clk,
   input  logic                 i_reset,

   // Settings bus, shared by all registers
   input  logic                 i_set_stb,
   input  logic [SR_AWIDTH-1:0] i_set_addr,
   input  logic [DATA_W-1:0]    i_set_data,

   // Register contents
   output logic [WIDTH-1:0]     o_value
);

   // Strobe aimed at this register
   logic hit;

   assign hit = i_set_stb && (i_set_addr == MY_ADDR);

   // ------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_value <= AT_RESET;
      end else if (hit) begin
         // Upper data bits dropped
         o_value <= i_set_data[WIDTH-1:0];
      end
   end

endmodule

// ==== logic/sfp_status_monitor.sv ====
// ----------------------------------------------------------------------
// SFP+ cage monitor: pin and PHY status synchronizers,
// sticky change flags and the packed status word
// ----------------------------------------------------------------------
module sfp_status_monitor
   import bus_int_pkg::*;
(
   input  logic                    clk,
   input  logic                    i_reset,

   // Cage pins, asynchronous
   input  logic                    i_mod_abs,
   input  logic                    i_tx_fault,
   input  logic                    i_rx_los,

   // PHY status from the Ethernet core, all bits asynchronous
   input  logic [PHY_STATUS_W-1:0] i_phy_status,

   // Status word consumed by a readback
   input  logic                    i_read_clear,

   // Packed status word
   output logic [DATA_W-1:0]       o_status
);

   // Synchronizer chains, stage 0 samples the pins
   logic [SFPP_PIN_W-1:0]   cage_pipe [SYNC_STAGES];
   logic [PHY_STATUS_W-1:0] phy_pipe  [SYNC_STAGES];

   // Chain outputs
   logic [SFPP_PIN_W-1:0]   cage_sync;
   logic [PHY_STATUS_W-1:0] phy_sync;

   // One more stage for edge detection
   logic [SFPP_PIN_W-1:0]   cage_prev;

   // Sticky flags, one per cage pin
   logic [SFPP_PIN_W-1:0]   cage_chgd;

   // ------------------------------------------------------------------
   // Synchronizers
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      // Pin order: absent, fault, loss
      cage_pipe[0] <= {i_mod_abs, i_tx_fault, i_rx_los};
      phy_pipe[0]  <= i_phy_status;
      for (int s = 1; s < SYNC_STAGES; s++) begin
         cage_pipe[s] <= cage_pipe[s-1];
         phy_pipe[s]  <= phy_pipe[s-1];
      end
   end

   assign cage_sync = cage_pipe[SYNC_STAGES-1];
   assign phy_sync  = phy_pipe[SYNC_STAGES-1];

   // Previous synchronized value
   always_ff @(posedge clk) begin
      cage_prev <= cage_sync;
   end

   // ------------------------------------------------------------------
   // Change flags
   // ------------------------------------------------------------------

   // Clear has priority over a change in the same cycle
   always_ff @(posedge clk) begin
      if (i_reset || i_read_clear) begin
         cage_chgd <= '0;
      end else begin
         for (int b = 0; b < SFPP_PIN_W; b++) begin
            // Any edge on a pin sets its flag
            if (cage_sync[b] != cage_prev[b]) begin
               cage_chgd[b] <= 1'b1;
            end
         end
      end
   end

   // ------------------------------------------------------------------
   // Status word
   // ------------------------------------------------------------------

   // PHY status on top, padding, then flags over live pins
   assign o_status = {
      phy_sync,
      {(DATA_W - PHY_STATUS_W - 2*SFPP_PIN_W){1'b0}},
      cage_chgd,
      cage_sync
   };

endmodule

// ==== logic/readback_mux.sv ====
// ----------------------------------------------------------------------
// Readback port: free-running cycle counter and address-decoded
// data selector
// ----------------------------------------------------------------------
module readback_mux
   import bus_int_pkg::*;
(
   input  logic                    clk,
   input  logic                    i_reset,

   // Readback address, data follows in the same cycle
   input  logic [RB_AWIDTH-1:0]    i_rb_addr,

   // Live sources
   input  logic [CLK_STATUS_W-1:0] i_clock_status,
   input  logic [DATA_W-1:0]       i_sfpp0_status,
   input  logic [DATA_W-1:0]       i_sfpp1_status,

   // Selected word
   output logic [DATA_W-1:0]       o_rb_data
);

   // Cycles since reset, wraps
   logic [DATA_W-1:0] counter;

   // Address decoded against the map
   rb_addr_e          rb_sel;

   // Fixed words
   logic [DATA_W-1:0] compat_word;
   logic [DATA_W-1:0] eth_type0_word;
   logic [DATA_W-1:0] eth_type1_word;
   logic [DATA_W-1:0] clk_status_word;

   // ------------------------------------------------------------------
   // Cycle counter
   // ------------------------------------------------------------------

   // Host uses two reads to measure elapsed bus cycles
   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // Word assembly
   // ------------------------------------------------------------------

   // Major in the upper half
   assign compat_word = {COMPAT_MAJOR, COMPAT_MINOR};

   // Port types, 1 for 10G
   assign eth_type0_word = {{(DATA_W-1){1'b0}}, ETH10G_PORT0};
   assign eth_type1_word = {{(DATA_W-1){1'b0}}, ETH10G_PORT1};

   // Clock status zero-extended
   assign clk_status_word = {{(DATA_W - CLK_STATUS_W){1'b0}}, i_clock_status};

   // ------------------------------------------------------------------
   // Selector
   // ------------------------------------------------------------------

   // Values outside the map fall to the default arm
   assign rb_sel = rb_addr_e'(i_rb_addr);

   always_comb begin
      case (rb_sel)
         RB_COUNTER: begin
            o_rb_data = counter;
         end
         RB_CLK_STATUS: begin
            o_rb_data = clk_status_word;
         end
         // Build configuration
         RB_ETH_TYPE0: begin
            o_rb_data = eth_type0_word;
         end
         RB_ETH_TYPE1: begin
            o_rb_data = eth_type1_word;
         end
         RB_COMPAT_NUM: begin
            o_rb_data = compat_word;
         end
         // SFP+ cage status, flags cleared by the top on a consumed read
         RB_SFPP_STATUS0: begin
            o_rb_data = i_sfpp0_status;
         end
         RB_SFPP_STATUS1: begin
            o_rb_data = i_sfpp1_status;
         end
         // Unused addresses
         default: begin
            o_rb_data = '0;
         end
      endcase
   end

endmodule

// ==== logic/bus_int_ctrl.sv ====
// ----------------------------------------------------------------------
// Board-control register block top level: settings registers,
// SFP+ monitors, readback selector and read-clear decode
// ----------------------------------------------------------------------
module bus_int_ctrl
   import bus_int_pkg::*;
(
   input  logic                    clk,
   input  logic                    i_reset,

   // Settings bus
   input  logic                    i_set_stb,
   input  logic [SR_AWIDTH-1:0]    i_set_addr,
   input  logic [DATA_W-1:0]       i_set_data,

   // Readback port
   input  logic [RB_AWIDTH-1:0]    i_rb_addr,
   input  logic                    i_rb_rd_stb,
   output logic [DATA_W-1:0]       o_rb_data,

   // Clocking
   input  logic [CLK_STATUS_W-1:0] i_clock_status,
   output logic [CLK_CTRL_W-1:0]   o_clock_control,

   // SFP+ cage 0 and its PHY
   input  logic                    i_sfpp0_mod_abs,
   input  logic                    i_sfpp0_tx_fault,
   input  logic                    i_sfpp0_rx_los,
   input  logic [PHY_STATUS_W-1:0] i_eth0_phy_status,
   output logic [SFPP_CTRL_W-1:0]  o_sfpp0_rs_drive_low,

   // SFP+ cage 1 and its PHY
   input  logic                    i_sfpp1_mod_abs,
   input  logic                    i_sfpp1_tx_fault,
   input  logic                    i_sfpp1_rx_los,
   input  logic [PHY_STATUS_W-1:0] i_eth1_phy_status,
   output logic [SFPP_CTRL_W-1:0]  o_sfpp1_rs_drive_low,

   // Board controls
   output logic [LED_W-1:0]        o_leds,
   output logic [SW_RST_W-1:0]     o_sw_rst
);

   // Status words headed for the readback selector
   logic [DATA_W-1:0] sfpp0_status;
   logic [DATA_W-1:0] sfpp1_status;

   // Consumed read of a status word
   logic sfpp0_read_clear;
   logic sfpp1_read_clear;

   // ------------------------------------------------------------------
   // Settings registers
   // ------------------------------------------------------------------

   setting_reg #(.MY_ADDR(SR_LEDS), .WIDTH(LED_W), .AT_RESET('0)) u_leds (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_leds)
   );

   // Bit 0 PHY, bit 1 radio domain, bit 2 radio PLL, bit 3 spare
   setting_reg #(.MY_ADDR(SR_SW_RST), .WIDTH(SW_RST_W), .AT_RESET('0)) u_sw_rst (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_sw_rst)
   );

   // GPSDO on by default
   setting_reg #(
      .MY_ADDR  (SR_CLOCK_CTRL),
      .WIDTH    (CLK_CTRL_W),
      .AT_RESET (CLK_CTRL_AT_RESET)
   ) u_clk_ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_clock_control)
   );

   // Rate selects, a set bit pulls RS0 or RS1 low at the pad
   setting_reg #(.MY_ADDR(SR_SFPP_CTRL0), .WIDTH(SFPP_CTRL_W), .AT_RESET('0)) u_sfpp0_ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_sfpp0_rs_drive_low)
   );

   setting_reg #(.MY_ADDR(SR_SFPP_CTRL1), .WIDTH(SFPP_CTRL_W), .AT_RESET('0)) u_sfpp1_ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_value    (o_sfpp1_rs_drive_low)
   );

   // ------------------------------------------------------------------
   // SFP+ monitors
   // ------------------------------------------------------------------

   // Flags clear only on a consumed read of that port's word
   assign sfpp0_read_clear = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS0);
   assign sfpp1_read_clear = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS1);

   sfp_status_monitor u_sfpp0_mon (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_mod_abs    (i_sfpp0_mod_abs),
      .i_tx_fault   (i_sfpp0_tx_fault),
      .i_rx_los     (i_sfpp0_rx_los),
      .i_phy_status (i_eth0_phy_status),
      .i_read_clear (sfpp0_read_clear),
      .o_status     (sfpp0_status)
   );

   sfp_status_monitor u_sfpp1_mon (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_mod_abs    (i_sfpp1_mod_abs),
      .i_tx_fault   (i_sfpp1_tx_fault),
      .i_rx_los     (i_sfpp1_rx_los),
      .i_phy_status (i_eth1_phy_status),
      .i_read_clear (sfpp1_read_clear),
      .o_status     (sfpp1_status)
   );

   // ------------------------------------------------------------------
   // Readback
   // ------------------------------------------------------------------

   readback_mux u_readback (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_rb_addr      (i_rb_addr),
      .i_clock_status (i_clock_status),
      .i_sfpp0_status (sfpp0_status),
      .i_sfpp1_status (sfpp1_status),
      .o_rb_data      (o_rb_data)
   );

endmodule

// ==== tb/bus_int_props.sv ====
// ----------------------------------------------------------------------
// Cycle-level assertions for the register block, bound into the top
// ----------------------------------------------------------------------
module bus_int_props
   import bus_int_pkg::*;
(
   input logic                    clk,
   input logic                    i_reset,
   input logic                    i_set_stb,
   input logic [SR_AWIDTH-1:0]    i_set_addr,
   input logic [DATA_W-1:0]       i_set_data,
   input logic [RB_AWIDTH-1:0]    i_rb_addr,
   input logic                    i_rb_rd_stb,
   input logic [LED_W-1:0]        o_leds,
   input logic [SW_RST_W-1:0]     o_sw_rst,
   input logic [CLK_CTRL_W-1:0]   o_clock_control,
   input logic [SFPP_CTRL_W-1:0]  o_sfpp0_rs_drive_low,
   input logic [SFPP_CTRL_W-1:0]  o_sfpp1_rs_drive_low,
   input logic                    i_sfpp0_mod_abs,
   input logic                    i_sfpp0_tx_fault,
   input logic                    i_sfpp0_rx_los,
   input logic                    i_sfpp1_mod_abs,
   input logic                    i_sfpp1_tx_fault,
   input logic                    i_sfpp1_rx_los,
   input logic [DATA_W-1:0]       sfpp0_status,
   input logic [DATA_W-1:0]       sfpp1_status
);
   timeunit 1ns;
   timeprecision 100ps;

   // Failed assertions so far, watched by the testbench
   int fail_count = 0;

   // Registers at their reset values right after reset
   a_reset_vals: assert property (@(posedge clk) $fell(i_reset) |->
      o_leds == '0 && o_sw_rst == '0 && o_clock_control == CLK_CTRL_AT_RESET &&
      o_sfpp0_rs_drive_low == '0 && o_sfpp1_rs_drive_low == '0)
      else begin fail_count++; $error("registers not at reset values"); end

   // ------------------------------------------------------------------
   // Each register loads on its own address, holds otherwise
   a_leds: assert property (@(posedge clk) disable iff (i_reset) 1 |=>
      o_leds == ($past(i_set_stb && i_set_addr == SR_LEDS) ?
                 $past(i_set_data[LED_W-1:0]) : $past(o_leds)))
      else begin fail_count++; $error("LED register wrong"); end
   a_sw_rst: assert property (@(posedge clk) disable iff (i_reset) 1 |=>
      o_sw_rst == ($past(i_set_stb && i_set_addr == SR_SW_RST) ?
                   $past(i_set_data[SW_RST_W-1:0]) : $past(o_sw_rst)))
      else begin fail_count++; $error("soft reset register wrong"); end
   a_clk_ctrl: assert property (@(posedge clk) disable iff (i_reset) 1 |=>
      o_clock_control == ($past(i_set_stb && i_set_addr == SR_CLOCK_CTRL) ?
                          $past(i_set_data[CLK_CTRL_W-1:0]) : $past(o_clock_control)))
      else begin fail_count++; $error("clock control register wrong"); end
   a_sfpp0_ctrl: assert property (@(posedge clk) disable iff (i_reset) 1 |=>
      o_sfpp0_rs_drive_low == ($past(i_set_stb && i_set_addr == SR_SFPP_CTRL0) ?
         $past(i_set_data[SFPP_CTRL_W-1:0]) : $past(o_sfpp0_rs_drive_low)))
      else begin fail_count++; $error("rate select 0 register wrong"); end
   a_sfpp1_ctrl: assert property (@(posedge clk) disable iff (i_reset) 1 |=>
      o_sfpp1_rs_drive_low == ($past(i_set_stb && i_set_addr == SR_SFPP_CTRL1) ?
         $past(i_set_data[SFPP_CTRL_W-1:0]) : $past(o_sfpp1_rs_drive_low)))
      else begin fail_count++; $error("rate select 1 register wrong"); end

   // ------------------------------------------------------------------
   // Synchronized pins lag the cage by the synchronizer depth
   a_sync0: assert property (@(posedge clk) disable iff (i_reset) sfpp0_status[2:0] ==
      $past({i_sfpp0_mod_abs, i_sfpp0_tx_fault, i_sfpp0_rx_los}, SYNC_STAGES))
      else begin fail_count++; $error("cage 0 pins not synchronized"); end
   a_sync1: assert property (@(posedge clk) disable iff (i_reset) sfpp1_status[2:0] ==
      $past({i_sfpp1_mod_abs, i_sfpp1_tx_fault, i_sfpp1_rx_los}, SYNC_STAGES))
      else begin fail_count++; $error("cage 1 pins not synchronized"); end

   // Consumed read clears all three flags of that port
   a_clear0: assert property (@(posedge clk) disable iff (i_reset)
      i_rb_rd_stb && i_rb_addr == RB_SFPP_STATUS0 |=> sfpp0_status[5:3] == '0)
      else begin fail_count++; $error("cage 0 flags not cleared by read"); end
   a_clear1: assert property (@(posedge clk) disable iff (i_reset)
      i_rb_rd_stb && i_rb_addr == RB_SFPP_STATUS1 |=> sfpp1_status[5:3] == '0)
      else begin fail_count++; $error("cage 1 flags not cleared by read"); end

endmodule

bind bus_int_ctrl bus_int_props props_i (.*);

// ==== tb/bus_int_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the register block: LFSR stimulus and readback checks
// ----------------------------------------------------------------------
module bus_int_tb
   import bus_int_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   // Clock and DUT inputs
   logic                    clk = 1'b0;
   logic                    i_reset = 1'b1;
   logic                    i_set_stb = 1'b0;
   logic [SR_AWIDTH-1:0]    i_set_addr = '0;
   logic [DATA_W-1:0]       i_set_data = '0;
   logic [RB_AWIDTH-1:0]    i_rb_addr = '0;
   logic                    i_rb_rd_stb = 1'b0;
   logic [CLK_STATUS_W-1:0] i_clock_status = '0;
   // Cage pins in status order: absent, fault, loss
   logic [SFPP_PIN_W-1:0]   pins0 = '0;
   logic [SFPP_PIN_W-1:0]   pins1 = '0;
   logic [PHY_STATUS_W-1:0] phy0 = '0;
   logic [PHY_STATUS_W-1:0] phy1 = '0;

   // DUT outputs
   logic [DATA_W-1:0]       o_rb_data;
   logic [LED_W-1:0]        o_leds;
   logic [SW_RST_W-1:0]     o_sw_rst;
   logic [CLK_CTRL_W-1:0]   o_clock_control;
   logic [SFPP_CTRL_W-1:0]  o_sfpp0_rs_drive_low;
   logic [SFPP_CTRL_W-1:0]  o_sfpp1_rs_drive_low;

   // Stimulus state
   logic [31:0]             lfsr = 32'h54f5_ff8e;
   sr_addr_e                sr_list [5] = '{
      SR_LEDS, SR_SW_RST, SR_CLOCK_CTRL, SR_SFPP_CTRL0, SR_SFPP_CTRL1
   };
   logic [4:0]              covered = '0;
   logic [RB_AWIDTH-1:0]    odd_addr;
   logic [DATA_W-1:0]       rd;
   // Expected port 1 flags after its pin toggle
   logic [SFPP_PIN_W-1:0]   flags1;
   int                      idx;
   int                      n;
   int                      tries;
   int                      b0;
   int                      b1;

   always #4 clk = ~clk;

   bus_int_ctrl dut_i (
      .clk (clk), .i_reset (i_reset),
      .i_set_stb (i_set_stb), .i_set_addr (i_set_addr), .i_set_data (i_set_data),
      .i_rb_addr (i_rb_addr), .i_rb_rd_stb (i_rb_rd_stb), .o_rb_data (o_rb_data),
      .i_clock_status (i_clock_status), .o_clock_control (o_clock_control),
      .i_sfpp0_mod_abs (pins0[2]), .i_sfpp0_tx_fault (pins0[1]), .i_sfpp0_rx_los (pins0[0]),
      .i_eth0_phy_status (phy0), .o_sfpp0_rs_drive_low (o_sfpp0_rs_drive_low),
      .i_sfpp1_mod_abs (pins1[2]), .i_sfpp1_tx_fault (pins1[1]), .i_sfpp1_rx_los (pins1[0]),
      .i_eth1_phy_status (phy1), .o_sfpp1_rs_drive_low (o_sfpp1_rs_drive_low),
      .o_leds (o_leds), .o_sw_rst (o_sw_rst)
   );

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] next_bits(input int count);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic stop_on_timeout(input string what);
      $display("TEST FAIL");
      $display("timeout while waiting for %s", what);
      $fatal(1);
   endtask

   task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] act);
      if (act !== expv) begin
         $display("TEST FAIL");
         $display("error %s expected %h actual %h", name, expv, act);
         $fatal(1);
      end
   endtask

   // Address set on the edge, data sampled mid-cycle
   task automatic read_word(input logic [RB_AWIDTH-1:0] addr, output logic [31:0] data);
      @(posedge clk);
      i_rb_addr <= addr;
      @(negedge clk);
      data = o_rb_data;
   endtask

   // One-cycle consumed read of a status word
   task automatic consume_word(input logic [RB_AWIDTH-1:0] addr);
      @(posedge clk);
      i_rb_addr <= addr;
      i_rb_rd_stb <= 1'b1;
      @(posedge clk);
      i_rb_rd_stb <= 1'b0;
   endtask

   // Poll a status word until the flag of one pin shows
   task automatic wait_flag(input logic [RB_AWIDTH-1:0] addr, input int pin,
                            input string what);
      int          count;
      logic [31:0] data;
      count = 0;
      do begin
         count++;
         if (count > 20) begin
            stop_on_timeout(what);
         end
         read_word(addr, data);
      end while (data[SFPP_PIN_W+pin] !== 1'b1);
   endtask

   // Bound assertions stop the run at their first failure
   always @(dut_i.props_i.fail_count) begin
      if (dut_i.props_i.fail_count != 0) begin
         $display("TEST FAIL");
         $display("a bound assertion failed");
         $fatal(1);
      end
   end

   initial begin
      repeat (4) @(posedge clk);
      i_reset <= 1'b0;
      // Random writes until every register address has been hit
      tries = 0;
      while (covered != 5'b11111) begin
         tries++;
         if (tries > 200) begin
            stop_on_timeout("all register addresses");
         end
         idx = next_bits(3) % 5;
         covered[idx] = 1'b1;
         @(posedge clk);
         i_set_stb <= 1'b1;
         i_set_addr <= sr_list[idx];
         i_set_data <= next_bits(32);
         @(posedge clk);
         i_set_stb <= 1'b0;
      end

      // ------------------------------------------------------------------
      // Constant and live words
      // ------------------------------------------------------------------
      i_clock_status <= next_bits(CLK_STATUS_W);
      read_word(RB_COMPAT_NUM, rd);
      compare("compat", {COMPAT_MAJOR, COMPAT_MINOR}, rd);
      read_word(RB_ETH_TYPE0, rd);
      compare("eth_type0", {31'd0, ETH10G_PORT0}, rd);
      read_word(RB_ETH_TYPE1, rd);
      compare("eth_type1", {31'd0, ETH10G_PORT1}, rd);
      read_word(RB_CLK_STATUS, rd);
      compare("clk_status", {27'd0, i_clock_status}, rd);
      // Upper half of the address space holds no words
      odd_addr = next_bits(RB_AWIDTH - 1);
      odd_addr[RB_AWIDTH-1] = 1'b1;
      read_word(odd_addr, rd);
      compare("unlisted", 32'd0, rd);
      // Counter advances once per cycle
      n = 5 + next_bits(4);
      read_word(RB_COUNTER, rd);
      repeat (n) @(negedge clk);
      compare("counter", rd + n, o_rb_data);

      // ------------------------------------------------------------------
      // SFP+ status and change flags
      // ------------------------------------------------------------------
      @(posedge clk);
      pins0 <= next_bits(3);
      pins1 <= next_bits(3);
      phy0 <= next_bits(16);
      phy1 <= next_bits(16);
      repeat (4) @(posedge clk);
      tries = 0;
      do begin
         tries++;
         if (tries > 20) begin
            stop_on_timeout("cage 0 pattern");
         end
         read_word(RB_SFPP_STATUS0, rd);
      end while (rd[2:0] !== pins0);
      // Pins rose from zero, so every high pin has its flag up
      compare("status0", {phy0, 10'd0, pins0, pins0}, rd);
      read_word(RB_SFPP_STATUS1, rd);
      compare("status1", {phy1, 10'd0, pins1, pins1}, rd);
      // Consumed read of port 0 leaves port 1 alone
      consume_word(RB_SFPP_STATUS0);
      read_word(RB_SFPP_STATUS1, rd);
      compare("status1_hold", {phy1, 10'd0, pins1, pins1}, rd);
      // One pin toggled on each cage
      b0 = next_bits(2) % 3;
      b1 = next_bits(2) % 3;
      flags1 = pins1 | (3'b001 << b1);
      @(posedge clk);
      pins0 <= pins0 ^ (3'b001 << b0);
      pins1 <= pins1 ^ (3'b001 << b1);
      wait_flag(RB_SFPP_STATUS0, b0, "cage 0 change flag");
      wait_flag(RB_SFPP_STATUS1, b1, "cage 1 change flag");
      // Flags stay up with no consumed read
      repeat (3) @(posedge clk);
      read_word(RB_SFPP_STATUS0, rd);
      compare("sticky0", {phy0, 10'd0, 3'b001 << b0, pins0}, rd);
      read_word(RB_SFPP_STATUS1, rd);
      compare("sticky1", {phy1, 10'd0, flags1, pins1}, rd);
      // Port 1 consumed, port 0 keeps its flag
      consume_word(RB_SFPP_STATUS1);
      read_word(RB_SFPP_STATUS0, rd);
      compare("sticky0_hold", {phy0, 10'd0, 3'b001 << b0, pins0}, rd);
      // Clear of a set port 0 flag
      consume_word(RB_SFPP_STATUS0);
      repeat (3) @(posedge clk);
      if (dut_i.props_i.fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Overall limit on the run
   initial begin
      #100us;
      stop_on_timeout("end of test");
   end

endmodule

// ==== list.f ====
logic/bus_int_pkg.sv
logic/setting_reg.sv
logic/sfp_status_monitor.sv
logic/readback_mux.sv
logic/bus_int_ctrl.sv
tb/bus_int_props.sv
tb/bus_int_tb.sv
